/* flist.f */
rtl/rv32i_types.sv
rtl/opnd_read_if.sv
rtl/issue_if.sv
rtl/cdb_if.sv
rtl/phys_regfile.sv
rtl/reservation.sv
rtl/alu_unit.sv
rtl/issue_top.sv
testbench/tb_issue_top.sv

/* rtl/alu_unit.sv */
`timescale 1ns/10ps

module alu_unit (
    input logic   clk,
    input logic   rst,
    issue_if.unit issue,
    cdb_if.source cdb
);
    import rv32i_types::*;

    localparam int cnt_w     = $clog2(mul_cycles + 1);
    // multiplier bits consumed per cycle
    localparam int step_bits = xlen / mul_cycles;

    logic            busy_q;
    logic [cnt_w-1:0] cnt_q;
    logic [xlen-1:0] acc_q;
    logic [xlen-1:0] mcand_q;
    logic [xlen-1:0] mplier_q;
    preg_t           mul_rd_q;
    rob_tag_t        mul_tag_q;
    logic            accept;
    logic            mul_accept;
    logic            mul_last;
    logic [xlen-1:0] first_step;
    logic [xlen-1:0] next_step;

    // one shift-add pass over a slice of the multiplier
    function automatic logic [xlen-1:0] mul_step(input logic [xlen-1:0]      acc,
                                                 input logic [xlen-1:0]      mcand,
                                                 input logic [step_bits-1:0] bits);
        logic [xlen-1:0] sum;
        sum = acc;
        for (int i = 0; i < step_bits; i++) begin
            if (bits[i]) begin
                sum = sum + (mcand << i);
            end
        end
        return sum;
    endfunction

    // single-cycle operations
    function automatic logic [xlen-1:0] alu_calc(input alu_op_t         op,
                                                 input logic [xlen-1:0] a,
                                                 input logic [xlen-1:0] b);
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_sll:  return a << b[4:0];
            alu_srl:  return a >> b[4:0];
            alu_sra:  return $signed(a) >>> b[4:0];
            alu_slt:  return {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: return {{(xlen-1){1'b0}}, a < b};
            default:  return '0;
        endcase
    endfunction

    // unit takes nothing while a multiply runs
    assign issue.ready = !busy_q;
    assign accept      = issue.valid && !busy_q;
    assign mul_accept  = accept && (issue.op == alu_mul);
    assign mul_last    = busy_q && (cnt_q == cnt_w'(1));

    // first slice is folded into the accept cycle
    assign first_step = mul_step('0, issue.a, issue.b[step_bits-1:0]);
    assign next_step  = mul_step(acc_q, mcand_q, mplier_q[step_bits-1:0]);

    // control and broadcast valid
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q    <= 1'b0;
            cnt_q     <= '0;
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= 1'b0;
            if (busy_q) begin
                cnt_q <= cnt_q - cnt_w'(1);
                if (mul_last) begin
                    busy_q    <= 1'b0;
                    cdb.valid <= 1'b1;
                end
            end else if (mul_accept) begin
                busy_q <= 1'b1;
                cnt_q  <= cnt_w'(mul_cycles - 1);
            end else if (accept) begin
                cdb.valid <= 1'b1;
            end
        end
    end

    // multiplier state and result payload
    always_ff @(posedge clk) begin
        if (busy_q) begin
            acc_q    <= next_step;
            mcand_q  <= mcand_q << step_bits;
            mplier_q <= mplier_q >> step_bits;
            if (mul_last) begin
                cdb.value <= next_step;
                cdb.rd    <= mul_rd_q;
                cdb.tag   <= mul_tag_q;
            end
        end else if (mul_accept) begin
            acc_q     <= first_step;
            mcand_q   <= issue.a << step_bits;
            mplier_q  <= issue.b >> step_bits;
            mul_rd_q  <= issue.rd;
            mul_tag_q <= issue.tag;
        end else if (accept) begin
            cdb.value <= alu_calc(issue.op, issue.a, issue.b);
            cdb.rd    <= issue.rd;
            cdb.tag   <= issue.tag;
        end
    end

endmodule

/* rtl/cdb_if.sv */
`timescale 1ns/10ps

interface cdb_if;
    import rv32i_types::*;

    // result broadcast, no back-pressure
    logic            valid;
    rob_tag_t        tag;
    preg_t           rd;
    logic [xlen-1:0] value;

    modport source (
        output valid, tag, rd, value
    );

    // station and register file both listen
    modport listener (
        input  valid, tag, rd, value
    );

endinterface

/* rtl/issue_if.sv */
`timescale 1ns/10ps

interface issue_if;
    import rv32i_types::*;

    // valid is raised whenever an entry is eligible
    logic            valid;
    logic            ready;
    alu_op_t         op;
    // a is rs1, b is rs2 or the immediate
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    preg_t           rd;
    rob_tag_t        tag;

    modport station (
        output valid, op, a, b, rd, tag,
        input  ready
    );

    modport unit (
        input  valid, op, a, b, rd, tag,
        output ready
    );

endinterface

/* rtl/issue_top.sv */
`timescale 1ns/10ps

module issue_top #(
    parameter int rs_depth = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          dispatch_valid,
    input  rv32i_types::alu_op_t          dispatch_op,
    input  rv32i_types::preg_t            dispatch_rs1,
    input  rv32i_types::preg_t            dispatch_rs2,
    input  rv32i_types::preg_t            dispatch_rd,
    input  logic [31:0]                   dispatch_imm,
    input  logic                          dispatch_use_imm,
    input  rv32i_types::rob_tag_t         dispatch_tag,
    output logic                          dispatch_ready,
    output logic                          result_valid,
    output rv32i_types::rob_tag_t         result_tag,
    output rv32i_types::preg_t            result_rd,
    output logic [rv32i_types::xlen-1:0]  result_value
);

    // station to register file
    opnd_read_if opnd ();
    // station to functional unit
    issue_if     issue ();
    // unit result broadcast
    cdb_if       cdb ();

    reservation #(
        .rs_depth (rs_depth)
    ) i_reservation (
        .clk              (clk),
        .rst              (rst),
        .dispatch_valid   (dispatch_valid),
        .dispatch_op      (dispatch_op),
        .dispatch_rs1     (dispatch_rs1),
        .dispatch_rs2     (dispatch_rs2),
        .dispatch_rd      (dispatch_rd),
        .dispatch_imm     (dispatch_imm),
        .dispatch_use_imm (dispatch_use_imm),
        .dispatch_tag     (dispatch_tag),
        .dispatch_ready   (dispatch_ready),
        .opnd             (opnd.station),
        .issue            (issue.station),
        .cdb              (cdb.listener)
    );

    phys_regfile i_phys_regfile (
        .clk  (clk),
        .rst  (rst),
        .opnd (opnd.regfile),
        .cdb  (cdb.listener)
    );

    alu_unit i_alu_unit (
        .clk   (clk),
        .rst   (rst),
        .issue (issue.unit),
        .cdb   (cdb.source)
    );

    // result bus leaves the subsystem as is
    assign result_valid = cdb.valid;
    assign result_tag   = cdb.tag;
    assign result_rd    = cdb.rd;
    assign result_value = cdb.value;

endmodule

/* rtl/opnd_read_if.sv */
`timescale 1ns/10ps

interface opnd_read_if;
    import rv32i_types::*;

    // source lookups for the instruction being dispatched
    preg_t           rd_idx1;
    preg_t           rd_idx2;
    logic [xlen-1:0] value1;
    logic [xlen-1:0] value2;
    logic            ready1;
    logic            ready2;

    // destination marked busy on dispatch
    logic            alloc_valid;
    preg_t           alloc_rd;

    modport station (
        output rd_idx1, rd_idx2, alloc_valid, alloc_rd,
        input  value1, value2, ready1, ready2
    );

    modport regfile (
        input  rd_idx1, rd_idx2, alloc_valid, alloc_rd,
        output value1, value2, ready1, ready2
    );

endinterface

/* rtl/phys_regfile.sv */
`timescale 1ns/10ps

module phys_regfile (
    input logic          clk,
    input logic          rst,
    opnd_read_if.regfile opnd,
    cdb_if.listener      cdb
);
    import rv32i_types::*;

    logic [xlen-1:0]       value_q [preg_count];
    logic [preg_count-1:0] ready_q;
    logic                  cdb_write;
    logic                  alloc_write;

    // register 0 is never written and never marked busy
    assign cdb_write   = cdb.valid && (cdb.rd != '0);
    assign alloc_write = opnd.alloc_valid && (opnd.alloc_rd != '0);

    // values start at zero so early reads of untouched registers are defined
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < preg_count; i++) begin
                value_q[i] <= '0;
            end
        end else if (cdb_write) begin
            value_q[cdb.rd] <= cdb.value;
        end
    end

    // ready bits
    always_ff @(posedge clk) begin
        if (rst) begin
            ready_q <= '1;
        end else begin
            if (cdb_write) begin
                ready_q[cdb.rd] <= 1'b1;
            end
            // allocation comes last so it wins on the same register
            if (alloc_write) begin
                ready_q[opnd.alloc_rd] <= 1'b0;
            end
        end
    end

    // combinational read ports, x0 forced to zero and ready
    always_comb begin
        if (opnd.rd_idx1 == '0) begin
            opnd.value1 = '0;
            opnd.ready1 = 1'b1;
        end else begin
            opnd.value1 = value_q[opnd.rd_idx1];
            opnd.ready1 = ready_q[opnd.rd_idx1];
        end
        if (opnd.rd_idx2 == '0) begin
            opnd.value2 = '0;
            opnd.ready2 = 1'b1;
        end else begin
            opnd.value2 = value_q[opnd.rd_idx2];
            opnd.ready2 = ready_q[opnd.rd_idx2];
        end
    end

endmodule

/* rtl/reservation.sv */
`timescale 1ns/10ps

module reservation #(
    parameter int rs_depth = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          dispatch_valid,
    input  rv32i_types::alu_op_t          dispatch_op,
    input  rv32i_types::preg_t            dispatch_rs1,
    input  rv32i_types::preg_t            dispatch_rs2,
    input  rv32i_types::preg_t            dispatch_rd,
    input  logic [rv32i_types::xlen-1:0]  dispatch_imm,
    input  logic                          dispatch_use_imm,
    input  rv32i_types::rob_tag_t         dispatch_tag,
    output logic                          dispatch_ready,
    opnd_read_if.station                  opnd,
    issue_if.station                      issue,
    cdb_if.listener                       cdb
);
    import rv32i_types::*;

    localparam int idx_w = (rs_depth > 1) ? $clog2(rs_depth) : 1;

    reservation_entry_t    table_q [rs_depth];
    // older_q[i][j] set means entry j was dispatched before entry i
    logic [rs_depth-1:0]   older_q [rs_depth];
    logic [rs_depth-1:0]   entry_valid;
    logic [rs_depth-1:0]   eligible;
    logic [rs_depth-1:0]   grant;
    logic [idx_w-1:0]      alloc_idx;
    logic [idx_w-1:0]      issue_idx;
    logic                  alloc_en;
    logic                  issue_fire;
    logic                  rs1_bypass;
    logic                  rs2_bypass;
    dispatch_reservation_t new_inst;
    dispatch_reservation_t sel_inst;

    // per entry status
    always_comb begin
        for (int i = 0; i < rs_depth; i++) begin
            entry_valid[i] = table_q[i].valid;
            eligible[i]    = table_q[i].valid && table_q[i].inst.rs1_met
                             && table_q[i].inst.rs2_met;
        end
    end

    // full when every slot holds an instruction
    assign dispatch_ready = ~&entry_valid;
    assign alloc_en       = dispatch_valid && dispatch_ready;

    // lowest free slot
    always_comb begin
        alloc_idx = '0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (!entry_valid[i]) begin
                alloc_idx = idx_w'(i);
            end
        end
    end

    // operand lookup and destination allocation
    assign opnd.rd_idx1     = dispatch_rs1;
    assign opnd.rd_idx2     = dispatch_rs2;
    assign opnd.alloc_valid = alloc_en;
    assign opnd.alloc_rd    = dispatch_rd;

    // result landing this cycle is not yet in the register file
    assign rs1_bypass = cdb.valid && (cdb.rd == dispatch_rs1) && (dispatch_rs1 != '0);
    assign rs2_bypass = cdb.valid && (cdb.rd == dispatch_rs2) && (dispatch_rs2 != '0);

    // build the entry for the incoming instruction
    always_comb begin
        new_inst.op         = dispatch_op;
        new_inst.rs1_source = dispatch_rs1;
        new_inst.rs2_source = dispatch_rs2;
        new_inst.rs1_met    = opnd.ready1 | rs1_bypass;
        new_inst.rs1_value  = rs1_bypass ? cdb.value : opnd.value1;
        // an immediate leaves nothing to wait for on rs2
        new_inst.rs2_met    = dispatch_use_imm | opnd.ready2 | rs2_bypass;
        new_inst.rs2_value  = rs2_bypass ? cdb.value : opnd.value2;
        new_inst.use_imm    = dispatch_use_imm;
        new_inst.imm        = dispatch_imm;
        new_inst.rd         = dispatch_rd;
        new_inst.tag        = dispatch_tag;
    end

    // oldest eligible entry, blocked if any older one is also eligible
    always_comb begin
        for (int i = 0; i < rs_depth; i++) begin
            grant[i] = eligible[i] && !(|(older_q[i] & eligible));
        end
    end

    // grant is one-hot
    always_comb begin
        issue_idx = '0;
        for (int i = 0; i < rs_depth; i++) begin
            if (grant[i]) begin
                issue_idx = idx_w'(i);
            end
        end
    end

    assign sel_inst = table_q[issue_idx].inst;

    // issue port
    assign issue.valid = |grant;
    assign issue.op    = sel_inst.op;
    assign issue.a     = sel_inst.rs1_value;
    assign issue.b     = sel_inst.use_imm ? sel_inst.imm : sel_inst.rs2_value;
    assign issue.rd    = sel_inst.rd;
    assign issue.tag   = sel_inst.tag;
    assign issue_fire  = issue.valid && issue.ready;

    // station table with wakeup, release and insert
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rs_depth; i++) begin
                table_q[i].valid <= 1'b0;
            end
        end else begin
            // wakeup from the result bus
            for (int i = 0; i < rs_depth; i++) begin
                if (cdb.valid && !table_q[i].inst.rs1_met
                    && (table_q[i].inst.rs1_source == cdb.rd)) begin
                    table_q[i].inst.rs1_met   <= 1'b1;
                    table_q[i].inst.rs1_value <= cdb.value;
                end
                if (cdb.valid && !table_q[i].inst.rs2_met
                    && (table_q[i].inst.rs2_source == cdb.rd)) begin
                    table_q[i].inst.rs2_met   <= 1'b1;
                    table_q[i].inst.rs2_value <= cdb.value;
                end
            end
            // freed once the unit takes it
            if (issue_fire) begin
                table_q[issue_idx].valid <= 1'b0;
            end
            // insert picks a slot that was free this cycle, never the issuing one
            if (alloc_en) begin
                table_q[alloc_idx].valid <= 1'b1;
                table_q[alloc_idx].inst  <= new_inst;
            end
        end
    end

    // age matrix
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rs_depth; i++) begin
                older_q[i] <= '0;
            end
        end else if (alloc_en) begin
            // new entry is younger than nobody yet
            for (int i = 0; i < rs_depth; i++) begin
                older_q[i][alloc_idx] <= 1'b0;
            end
            // and younger than everything already present
            older_q[alloc_idx] <= entry_valid;
        end
    end

endmodule

/* rtl/rv32i_types.sv */
package rv32i_types;

    // data path width, one machine word
    localparam int xlen = 32;

    // physical register file size
    localparam int preg_count = 32;

    // cycles the multiplier holds the unit, issue cycle to broadcast
    localparam int mul_cycles = 4;

    // physical register index
    typedef logic [$clog2(preg_count)-1:0] preg_t;

    // reorder buffer tag
    typedef logic [3:0] rob_tag_t;

    // integer operations handled by the unit
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_sll  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9,
        alu_mul  = 4'd10
    } alu_op_t;

    // instruction as it sits in the station
    typedef struct packed {
        alu_op_t         op;
        preg_t           rs1_source;
        preg_t           rs2_source;
        logic            rs1_met;
        logic            rs2_met;
        logic [xlen-1:0] rs1_value;
        logic [xlen-1:0] rs2_value;
        logic            use_imm;
        logic [xlen-1:0] imm;
        preg_t           rd;
        rob_tag_t        tag;
    } dispatch_reservation_t;

    // one station slot
    typedef struct packed {
        logic                  valid;
        dispatch_reservation_t inst;
    } reservation_entry_t;

endpackage

/* testbench/tb_issue_top.sv */
`timescale 1ns/10ps

module tb_issue_top;
    import rv32i_types::*;

    localparam int rs_depth = 8;
    localparam int n_tags   = 16;
    // instructions per test group
    localparam int n_imm    = 20;
    localparam int n_chain  = 13;
    localparam int n_bp     = 20;
    localparam int n_age    = 6;
    localparam int n_rand   = 200;
    localparam int n_instr  = n_imm + n_chain + n_bp + n_age + n_rand;
    localparam int watchdog_cycles = n_instr * (mul_cycles + 2) + 200;
    // galois taps for x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;

    logic            clk;
    logic            rst;
    logic            dispatch_valid;
    alu_op_t         dispatch_op;
    preg_t           dispatch_rs1;
    preg_t           dispatch_rs2;
    preg_t           dispatch_rd;
    logic [31:0]     dispatch_imm;
    logic            dispatch_use_imm;
    rob_tag_t        dispatch_tag;
    logic            dispatch_ready;
    logic            result_valid;
    rob_tag_t        result_tag;
    preg_t           result_rd;
    logic [xlen-1:0] result_value;

    // architectural model in dispatch order
    logic [xlen-1:0]       model_reg [preg_count];
    // register has a producer still in flight
    logic [preg_count-1:0] busy;
    int                    writer [preg_count];
    // per tag scoreboard
    logic [xlen-1:0]       exp_value [n_tags];
    preg_t                 exp_rd [n_tags];
    logic [n_tags-1:0]     pending;
    logic [n_tags-1:0]     tag_mul;
    int                    tag_seq [n_tags];
    string                 tag_test [n_tags];
    // per instruction producers, -1 when the source was ready
    int                    dep1 [n_instr];
    int                    dep2 [n_instr];
    logic [n_instr-1:0]    done;
    logic [n_instr-1:0]    no_deps;
    // cycle history, replayed at the end for the occupancy rule
    logic                  ready_hist [watchdog_cycles];
    int                    add_hist [watchdog_cycles];
    int                    rem_hist [watchdog_cycles];
    int                    cyc;
    int                    accepted;
    int                    results_seen;
    int                    last_ready_seq;
    int                    err_value;
    int                    err_order;
    int                    err_flow;
    logic [31:0]           lfsr;
    string                 test_name;

    issue_top #(
        .rs_depth (rs_depth)
    ) i_dut (
        .clk              (clk),
        .rst              (rst),
        .dispatch_valid   (dispatch_valid),
        .dispatch_op      (dispatch_op),
        .dispatch_rs1     (dispatch_rs1),
        .dispatch_rs2     (dispatch_rs2),
        .dispatch_rd      (dispatch_rd),
        .dispatch_imm     (dispatch_imm),
        .dispatch_use_imm (dispatch_use_imm),
        .dispatch_tag     (dispatch_tag),
        .dispatch_ready   (dispatch_ready),
        .result_valid     (result_valid),
        .result_tag       (result_tag),
        .result_rd        (result_rd),
        .result_value     (result_value)
    );

    // 8 ns period
    always #4 clk = ~clk;

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ lfsr_taps) : (lfsr >> 1);
        end
        return r;
    endfunction

    // any register without a producer in flight, x0 included
    function automatic preg_t pick_ready();
        preg_t r;
        r = preg_t'(rand_bits(5));
        while (busy[r]) begin
            r = preg_t'(rand_bits(5));
        end
        return r;
    endfunction

    // destination that is not x0 and not in flight
    function automatic preg_t pick_free();
        preg_t r;
        r = preg_t'(rand_bits(5));
        while (busy[r] || r == '0) begin
            r = preg_t'(rand_bits(5));
        end
        return r;
    endfunction

    // expected result from the rv32i operation rules
    function automatic logic [xlen-1:0] ref_result(input alu_op_t op,
                                                   input logic [xlen-1:0] a,
                                                   input logic [xlen-1:0] b);
        logic [2*xlen-1:0] prod;
        logic [4:0]        sh;
        sh   = b[4:0];
        prod = {32'h0, a} * {32'h0, b};
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a + ~b + 32'd1;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_sll:  return a << sh;
            alu_srl:  return a >> sh;
            // sign fill into the vacated upper bits
            alu_sra:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            alu_slt:  return (a[31] != b[31]) ? {31'h0, a[31]} : {31'h0, a < b};
            alu_sltu: return {31'h0, a < b};
            alu_mul:  return prod[31:0];
            default:  return '0;
        endcase
    endfunction

    // holds the instruction until the station takes it
    task automatic send(input alu_op_t op, input preg_t rs1, input preg_t rs2,
                        input logic use_imm, input logic [31:0] imm, input preg_t rd);
        logic took;
        took = 1'b0;
        while (pending[accepted % n_tags]) begin
            @(posedge clk);
            #1;
        end
        dispatch_valid   = 1'b1;
        dispatch_op      = op;
        dispatch_rs1     = rs1;
        dispatch_rs2     = rs2;
        dispatch_use_imm = use_imm;
        dispatch_imm     = imm;
        dispatch_rd      = rd;
        dispatch_tag     = rob_tag_t'(accepted % n_tags);
        while (!took) begin
            @(negedge clk);
            took = dispatch_ready;
        end
        @(posedge clk);
        #1;
        dispatch_valid = 1'b0;
    endtask

    // wait for every accepted instruction to broadcast
    task automatic drain();
        dispatch_valid = 1'b0;
        while (accepted != results_seen) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    // results are handled before the handshake of the same cycle
    always @(negedge clk) begin
        int s;
        int t;
        int lat;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        if (rst) begin
            assert (!result_valid && dispatch_ready) else begin
                err_flow++;
                $display("result_valid high or dispatch_ready low during reset");
            end
        end else begin
            if (cyc == 0) begin
                assert (!result_valid && dispatch_ready) else begin
                    err_flow++;
                    $display("wrong result_valid or dispatch_ready right after reset");
                end
            end
            if (result_valid) begin
                t = result_tag;
                assert (pending[t]) else begin
                    err_order++;
                    $display("tag %0d on the result port with nothing in flight", t);
                end
                if (pending[t]) begin
                    s = tag_seq[t];
                    assert (result_value == exp_value[t]) else begin
                        err_value++;
                        $display("FAIL %s tag %0d value: expected %h, actual %h",
                                 tag_test[t], t, exp_value[t], result_value);
                    end
                    assert (result_rd == exp_rd[t]) else begin
                        err_value++;
                        $display("FAIL %s tag %0d rd: expected %0d, actual %0d",
                                 tag_test[t], t, exp_rd[t], result_rd);
                    end
                    if (dep1[s] >= 0) begin
                        assert (done[dep1[s]]) else begin
                            err_order++;
                            $display("tag %0d finished before its rs1 producer", t);
                        end
                    end
                    if (dep2[s] >= 0) begin
                        assert (done[dep2[s]]) else begin
                            err_order++;
                            $display("tag %0d finished before its rs2 producer", t);
                        end
                    end
                    // ready at dispatch means results in dispatch order
                    if (no_deps[s]) begin
                        assert (s > last_ready_seq) else begin
                            err_order++;
                            $display("tag %0d overtaken by a younger ready instruction", t);
                        end
                        last_ready_seq = s;
                    end
                    done[s]    = 1'b1;
                    pending[t] = 1'b0;
                    busy[exp_rd[t]] = 1'b0;
                    results_seen++;
                    // entry left the station at the end of its issue cycle
                    lat = tag_mul[t] ? mul_cycles : 1;
                    rem_hist[cyc - lat]++;
                end
            end
            ready_hist[cyc] = dispatch_ready;
            if (dispatch_valid && dispatch_ready) begin
                s = accepted;
                t = dispatch_tag;
                a = model_reg[dispatch_rs1];
                b = dispatch_use_imm ? dispatch_imm : model_reg[dispatch_rs2];
                dep1[s] = busy[dispatch_rs1] ? writer[dispatch_rs1] : -1;
                dep2[s] = (!dispatch_use_imm && busy[dispatch_rs2]) ? writer[dispatch_rs2] : -1;
                no_deps[s]   = (dep1[s] < 0) && (dep2[s] < 0);
                exp_value[t] = ref_result(dispatch_op, a, b);
                exp_rd[t]    = dispatch_rd;
                tag_mul[t]   = (dispatch_op == alu_mul);
                tag_seq[t]   = s;
                tag_test[t]  = test_name;
                pending[t]   = 1'b1;
                if (dispatch_rd != '0) begin
                    model_reg[dispatch_rd] = exp_value[t];
                    busy[dispatch_rd]      = 1'b1;
                    writer[dispatch_rd]    = s;
                end
                add_hist[cyc] = 1;
                accepted++;
            end
            cyc++;
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: %0d of %0d instructions finished", results_seen, n_instr);
        $display("errors: value %0d, order %0d, flow %0d", err_value, err_order, err_flow);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        alu_op_t     op;
        preg_t       src;
        preg_t       src2;
        preg_t       dst;
        preg_t       prev;
        logic        ui;
        logic [31:0] imm;
        int          occ;
        int          full_seen;
        preg_t       loaded [10];
        clk = 1'b0;
        rst = 1'b1;
        dispatch_valid   = 1'b0;
        dispatch_op      = alu_add;
        dispatch_rs1     = '0;
        dispatch_rs2     = '0;
        dispatch_rd      = '0;
        dispatch_imm     = '0;
        dispatch_use_imm = 1'b0;
        dispatch_tag     = '0;
        lfsr = 32'h7d9a;
        busy = '0;
        pending = '0;
        tag_mul = '0;
        done = '0;
        no_deps = '0;
        cyc = 0;
        accepted = 0;
        results_seen = 0;
        last_ready_seq = -1;
        err_value = 0;
        err_order = 0;
        err_flow = 0;
        for (int i = 0; i < preg_count; i++) begin
            model_reg[i] = '0;
            writer[i] = -1;
        end
        for (int c = 0; c < watchdog_cycles; c++) begin
            add_hist[c] = 0;
            rem_hist[c] = 0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;

        // every single-cycle op on x0, then on loaded registers
        test_name = "imm_ops";
        for (int i = 0; i < 10; i++) begin
            imm = rand_bits(32);
            loaded[i] = pick_free();
            send(alu_op_t'(i), '0, '0, 1'b1, imm, loaded[i]);
        end
        for (int i = 0; i < 10; i++) begin
            imm = rand_bits(32);
            dst = pick_free();
            send(alu_op_t'(i), loaded[i], '0, 1'b1, imm, dst);
        end
        drain();

        // each link reads the previous destination
        test_name = "chain";
        imm = rand_bits(32);
        prev = pick_free();
        send(alu_add, '0, '0, 1'b1, imm, prev);
        for (int i = 0; i < n_chain - 1; i++) begin
            op = (i % 3 == 2) ? alu_mul : alu_op_t'(rand_bits(4) % 10);
            ui = (i % 2 == 0);
            src = (i % 4 == 1) ? prev : pick_ready();
            imm = rand_bits(32);
            dst = pick_free();
            send(op, prev, ui ? '0 : src, ui, imm, dst);
            prev = dst;
        end
        drain();

        // slow mul chain, then independent work until the station fills
        test_name = "backpressure";
        imm = rand_bits(32);
        prev = pick_free();
        send(alu_add, '0, '0, 1'b1, imm, prev);
        for (int i = 0; i < 7; i++) begin
            imm = rand_bits(32) | 32'h1;
            dst = pick_free();
            send(alu_mul, prev, '0, 1'b1, imm, dst);
            prev = dst;
        end
        for (int i = 0; i < 12; i++) begin
            src = pick_ready();
            imm = rand_bits(32);
            dst = pick_free();
            send(alu_xor, src, '0, 1'b1, imm, dst);
        end
        drain();

        // ready instructions queued behind a running mul
        test_name = "age_order";
        src = pick_ready();
        imm = rand_bits(32);
        dst = pick_free();
        send(alu_mul, src, '0, 1'b1, imm, dst);
        for (int i = 0; i < n_age - 1; i++) begin
            src = pick_ready();
            imm = rand_bits(32);
            dst = pick_free();
            send(alu_op_t'(i), src, '0, 1'b1, imm, dst);
        end
        drain();

        test_name = "random";
        for (int i = 0; i < n_rand; i++) begin
            op = alu_op_t'(rand_bits(4) % 11);
            ui = rand_bits(1);
            src = pick_ready();
            src2 = pick_ready();
            imm = rand_bits(32);
            dst = pick_free();
            send(op, src, ui ? '0 : src2, ui, imm, dst);
        end
        drain();

        // replay: present from the cycle after the handshake until its issue cycle
        occ = 0;
        full_seen = 0;
        for (int c = 0; c < cyc; c++) begin
            assert (ready_hist[c] == (occ != rs_depth)) else begin
                err_flow++;
                $display("dispatch_ready %0b in cycle %0d with %0d entries held",
                         ready_hist[c], c, occ);
            end
            if (occ == rs_depth) begin
                full_seen++;
            end
            occ = occ + add_hist[c] - rem_hist[c];
        end
        assert (full_seen > 0) else begin
            err_flow++;
            $display("station never became full");
        end
        assert (accepted == n_instr && results_seen == n_instr) else begin
            err_order++;
            $display("%0d accepted and %0d finished out of %0d instructions",
                     accepted, results_seen, n_instr);
        end
        for (int t = 0; t < n_tags; t++) begin
            assert (!pending[t]) else begin
                err_order++;
                $display("tag %0d never reached the result port", t);
            end
        end
        $display("errors: value %0d, order %0d, flow %0d", err_value, err_order, err_flow);
        if (err_value + err_order + err_flow == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
